// ==== emu_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "emu_ram_consts.svh"

module emu_ram #(
    parameter int R_DELAY      = `EMU_RAM_R_DELAY,
    parameter int W_DELAY      = `EMU_RAM_W_DELAY,
    parameter int MAX_INFLIGHT = `EMU_RAM_MAX_INFLIGHT
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         awvalid,
    input  wire logic [`EMU_RAM_ID_W-1:0]     awid,
    input  wire logic [`EMU_RAM_ADDR_W-1:0]   awaddr,
    input  wire logic [7:0]                   awlen,
    input  wire logic [2:0]                   awsize,
    input  wire logic [1:0]                   awburst,
    output logic                              awready,
    input  wire logic                         wvalid,
    input  wire logic [`EMU_RAM_DATA_W-1:0]   wdata,
    input  wire logic [`EMU_RAM_DATA_W/8-1:0] wstrb,
    input  wire logic                         wlast,
    output logic                              wready,
    output logic [`EMU_RAM_ID_W-1:0]          bid,
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  wire logic                         bready,
    input  wire logic                         arvalid,
    input  wire logic [`EMU_RAM_ID_W-1:0]     arid,
    input  wire logic [`EMU_RAM_ADDR_W-1:0]   araddr,
    input  wire logic [7:0]                   arlen,
    input  wire logic [2:0]                   arsize,
    input  wire logic [1:0]                   arburst,
    output logic                              arready,
    output logic [`EMU_RAM_ID_W-1:0]          rid,
    output logic [`EMU_RAM_DATA_W-1:0]        rdata,
    output logic [1:0]                        rresp,
    output logic                              rlast,
    output logic                              rvalid,
    input  wire logic                         rready
);

    logic                           rd_en;
    logic [`EMU_RAM_ADDR_W-1:0]     rd_addr;
    logic [`EMU_RAM_ID_W-1:0]       rd_id;
    logic                           rd_last;
    logic                           wr_en;
    logic [`EMU_RAM_ADDR_W-1:0]     wr_addr;
    logic [`EMU_RAM_DATA_W-1:0]     wr_data;
    logic [`EMU_RAM_DATA_W/8-1:0]   wr_strb;
    logic                           b_push;
    logic                           r_push;
    logic                           r_dl_valid;
    logic                           b_dl_valid;
    logic                           r_credit_ok;
    logic                           b_credit_ok;
    emu_ram_pkg::b_beat_t           b_beat;
    emu_ram_pkg::b_beat_t           b_dl_data;
    emu_ram_pkg::b_beat_t           b_q_data;
    emu_ram_pkg::r_beat_t           r_beat;
    emu_ram_pkg::r_beat_t           r_dl_data;
    emu_ram_pkg::r_beat_t           r_q_data;

    assign bresp = 2'b00;   // always OKAY.
    assign rresp = 2'b00;
    assign bid   = b_q_data.id;
    assign rid   = r_q_data.id;
    assign rdata = r_q_data.data;
    assign rlast = r_q_data.last;

    emu_ram_frontend i_frontend (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awid(awid), .awaddr(awaddr), .awlen(awlen),
        .awsize(awsize), .awburst(awburst), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wready(wready),
        .arvalid(arvalid), .arid(arid), .araddr(araddr), .arlen(arlen),
        .arsize(arsize), .arburst(arburst), .arready(arready),
        .r_credit_ok(r_credit_ok), .b_credit_ok(b_credit_ok),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_id(rd_id), .rd_last(rd_last),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
        .b_push(b_push), .b_beat(b_beat)
    );

    emu_ram_store i_store (
        .clk(clk),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_id(rd_id), .rd_last(rd_last),
        .r_push(r_push), .r_beat(r_beat)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // read response path
    // ~~~~~~~~~~~~~~~~~~~~

    emu_ram_delay_line #(.payload_t(emu_ram_pkg::r_beat_t), .DEPTH(R_DELAY)) i_r_delay (
        .clk(clk), .rst(rst),
        .in_valid(r_push), .in_data(r_beat),
        .out_valid(r_dl_valid), .out_data(r_dl_data)
    );

    emu_ram_resp_queue #(.payload_t(emu_ram_pkg::r_beat_t), .DEPTH(MAX_INFLIGHT)) i_r_queue (
        .clk(clk), .rst(rst),
        .issue(rd_en), .in_valid(r_dl_valid), .in_data(r_dl_data),
        .credit_ok(r_credit_ok),
        .out_valid(rvalid), .out_data(r_q_data), .out_ready(rready)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // write response path
    // ~~~~~~~~~~~~~~~~~~~~

    emu_ram_delay_line #(.payload_t(emu_ram_pkg::b_beat_t), .DEPTH(W_DELAY)) i_b_delay (
        .clk(clk), .rst(rst),
        .in_valid(b_push), .in_data(b_beat),
        .out_valid(b_dl_valid), .out_data(b_dl_data)
    );

    emu_ram_resp_queue #(.payload_t(emu_ram_pkg::b_beat_t), .DEPTH(MAX_INFLIGHT)) i_b_queue (
        .clk(clk), .rst(rst),
        .issue(b_push), .in_valid(b_dl_valid), .in_data(b_dl_data),
        .credit_ok(b_credit_ok),
        .out_valid(bvalid), .out_data(b_q_data), .out_ready(bready)
    );

endmodule

`default_nettype wire

// ==== emu_ram_consts.svh ====
`ifndef EMU_RAM_CONSTS_SVH
`define EMU_RAM_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// bus widths
// ~~~~~~~~~~~~~~~~~~~~

`define EMU_RAM_ADDR_W        16   // byte address.
`define EMU_RAM_DATA_W        32
`define EMU_RAM_ID_W          4

// ~~~~~~~~~~~~~~~~~~~~
// storage and timing
// ~~~~~~~~~~~~~~~~~~~~

`define EMU_RAM_DEPTH         1024 // words before the address wraps.

`define EMU_RAM_R_DELAY       6    // extra cycles on the read path.
`define EMU_RAM_W_DELAY       3    // extra cycles before a write response.

`define EMU_RAM_MAX_INFLIGHT  8    // response beats outstanding per channel.

`endif

// ==== emu_ram_delay_line.sv ====
`timescale 1ns/1ns
`default_nettype none

module emu_ram_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data
);

    if (DEPTH < 1) begin : g_bad_depth
        $error("delay line needs at least one stage");
    end

    logic [DEPTH-1:0] vld;
    payload_t         data_q [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                vld[i] <= vld[i-1];
            end
        end
    end

    // payload shifts along with its valid bit.
    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = vld[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== emu_ram_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "emu_ram_consts.svh"

module emu_ram_frontend (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         awvalid,
    input  wire logic [`EMU_RAM_ID_W-1:0]     awid,
    input  wire logic [`EMU_RAM_ADDR_W-1:0]   awaddr,
    input  wire logic [7:0]                   awlen,
    input  wire logic [2:0]                   awsize,
    input  wire logic [1:0]                   awburst,
    output logic                              awready,
    input  wire logic                         wvalid,
    input  wire logic [`EMU_RAM_DATA_W-1:0]   wdata,
    input  wire logic [`EMU_RAM_DATA_W/8-1:0] wstrb,
    input  wire logic                         wlast,
    output logic                              wready,
    input  wire logic                         arvalid,
    input  wire logic [`EMU_RAM_ID_W-1:0]     arid,
    input  wire logic [`EMU_RAM_ADDR_W-1:0]   araddr,
    input  wire logic [7:0]                   arlen,
    input  wire logic [2:0]                   arsize,
    input  wire logic [1:0]                   arburst,
    output logic                              arready,
    input  wire logic                         r_credit_ok,
    input  wire logic                         b_credit_ok,
    output logic                              rd_en,
    output logic [`EMU_RAM_ADDR_W-1:0]        rd_addr,
    output logic [`EMU_RAM_ID_W-1:0]          rd_id,
    output logic                              rd_last,
    output logic                              wr_en,
    output logic [`EMU_RAM_ADDR_W-1:0]        wr_addr,
    output logic [`EMU_RAM_DATA_W-1:0]        wr_data,
    output logic [`EMU_RAM_DATA_W/8-1:0]      wr_strb,
    output logic                              b_push,
    output emu_ram_pkg::b_beat_t              b_beat
);

    localparam int OFFS_W = $clog2(`EMU_RAM_DATA_W / 8);
    localparam int WA_W = `EMU_RAM_ADDR_W - OFFS_W;
    localparam logic [2:0] SIZE_FULL = 3'(OFFS_W);
    localparam logic [1:0] BURST_INCR = 2'b01;

    typedef enum logic [1:0] {st_idle, st_write, st_wresp, st_read} state_t;

    state_t                         state;
    logic                           prio_wr;    // set after a read burst.
    logic [`EMU_RAM_ID_W-1:0]       id_q;
    logic [WA_W-1:0]                word_q;
    logic [7:0]                     left_q;     // beats after the current one.
    logic                           last_beat;
    logic [`EMU_RAM_ADDR_W-1:0]     beat_addr;

    assign last_beat = (left_q == 8'd0);
    assign beat_addr = {word_q, {OFFS_W{1'b0}}};

    // reads win a tie unless the last burst was a read.
    assign arready = (state == st_idle) && arvalid && (!prio_wr || !awvalid);
    assign awready = (state == st_idle) && awvalid && (prio_wr || !arvalid);

    // ~~~~~~~~~~~~~~~~~~~~
    // beat issue
    // ~~~~~~~~~~~~~~~~~~~~

    assign wready  = (state == st_write);
    assign wr_en   = wvalid && wready;
    assign wr_addr = beat_addr;
    assign wr_data = wdata;
    assign wr_strb = wstrb;
    assign b_push  = b_credit_ok && ((wr_en && last_beat) || (state == st_wresp));
    assign b_beat.id = id_q;

    assign rd_en   = (state == st_read) && r_credit_ok;
    assign rd_addr = beat_addr;
    assign rd_id   = id_q;
    assign rd_last = last_beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            prio_wr <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (arready) begin
                        state   <= st_read;
                        prio_wr <= 1'b1;
                    end else if (awready) begin
                        state   <= st_write;
                        prio_wr <= 1'b0;
                    end
                end
                st_write: begin
                    if (wr_en && last_beat) begin
                        state <= b_credit_ok ? st_idle : st_wresp; // hold B until credit.
                    end
                end
                st_wresp: begin
                    if (b_credit_ok) begin
                        state <= st_idle;
                    end
                end
                st_read: begin
                    if (rd_en && last_beat) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (arready) begin
            id_q   <= arid;
            word_q <= araddr[`EMU_RAM_ADDR_W-1:OFFS_W];
            left_q <= arlen;
        end else if (awready) begin
            id_q   <= awid;
            word_q <= awaddr[`EMU_RAM_ADDR_W-1:OFFS_W];
            left_q <= awlen;
        end else if (wr_en || rd_en) begin
            word_q <= word_q + 1'b1;    // wraps with the address space.
            left_q <= left_q - 1'b1;
        end
    end

    a_aw_incr_full: assert property (@(posedge clk) disable iff (rst)
        awvalid && awready |-> awburst == BURST_INCR && awsize == SIZE_FULL)
        else $error("write burst is not full-width INCR");

    a_ar_incr_full: assert property (@(posedge clk) disable iff (rst)
        arvalid && arready |-> arburst == BURST_INCR && arsize == SIZE_FULL)
        else $error("read burst is not full-width INCR");

    a_wlast_count: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> wlast == last_beat)
        else $error("wlast does not match awlen");

endmodule

`default_nettype wire

// ==== emu_ram_pkg.sv ====
`default_nettype none

`include "emu_ram_consts.svh"

package emu_ram_pkg;

    // one beat on the R channel.
    typedef struct packed {
        logic [`EMU_RAM_ID_W-1:0]   id;
        logic [`EMU_RAM_DATA_W-1:0] data;
        logic                       last;
    } r_beat_t;

    // one response on the B channel.
    typedef struct packed {
        logic [`EMU_RAM_ID_W-1:0]   id;
    } b_beat_t;

endpackage

`default_nettype wire

// ==== emu_ram_resp_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module emu_ram_resp_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     issue,
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          credit_ok,
    output logic          out_valid,
    output payload_t      out_data,
    input  wire logic     out_ready
);

    if (DEPTH < 2) begin : g_bad_depth
        $error("response queue needs at least two entries");
    end

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;     // entries held here.
    logic [CNT_W-1:0] credits;  // entries plus beats still upstream.
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop       = out_valid && out_ready;
    assign out_valid = (fill != '0);
    assign out_data  = mem[rd_ptr];
    assign credit_ok = (credits < CNT_W'(DEPTH));

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            fill    <= fill + CNT_W'(in_valid) - CNT_W'(pop);
            credits <= credits + CNT_W'(issue) - CNT_W'(pop);
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> fill != CNT_W'(DEPTH))
        else $error("beat arrived at a full response queue");

    a_credit_floor: assert property (@(posedge clk) disable iff (rst)
        pop |-> credits != '0)
        else $error("response credit underflow");

endmodule

`default_nettype wire

// ==== emu_ram_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "emu_ram_consts.svh"

module emu_ram_store (
    input  wire logic                         clk,
    input  wire logic                         wr_en,
    input  wire logic [`EMU_RAM_ADDR_W-1:0]   wr_addr,
    input  wire logic [`EMU_RAM_DATA_W-1:0]   wr_data,
    input  wire logic [`EMU_RAM_DATA_W/8-1:0] wr_strb,
    input  wire logic                         rd_en,
    input  wire logic [`EMU_RAM_ADDR_W-1:0]   rd_addr,
    input  wire logic [`EMU_RAM_ID_W-1:0]     rd_id,
    input  wire logic                         rd_last,
    output logic                              r_push,
    output emu_ram_pkg::r_beat_t              r_beat
);

    localparam int BYTES = `EMU_RAM_DATA_W / 8;
    localparam int OFFS_W = $clog2(BYTES);
    localparam int IDX_W = $clog2(`EMU_RAM_DEPTH);

    logic [`EMU_RAM_DATA_W-1:0] mem [`EMU_RAM_DEPTH];
    logic [IDX_W-1:0]           wr_idx;
    logic [IDX_W-1:0]           rd_idx;

    assign wr_idx = IDX_W'((wr_addr >> OFFS_W) % `EMU_RAM_DEPTH);
    assign rd_idx = IDX_W'((rd_addr >> OFFS_W) % `EMU_RAM_DEPTH);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // read beat leaves one cycle after rd_en.
    always_ff @(posedge clk) begin
        r_push      <= rd_en;
        r_beat.id   <= rd_id;
        r_beat.data <= mem[rd_idx];
        r_beat.last <= rd_last;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
emu_ram_pkg.sv
emu_ram_frontend.sv
emu_ram_store.sv
emu_ram_delay_line.sv
emu_ram_resp_queue.sv
emu_ram.sv
tb_emu_ram.sv

// ==== tb_emu_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "emu_ram_consts.svh"

module tb_emu_ram;

    localparam int R_DELAY      = `EMU_RAM_R_DELAY;
    localparam int W_DELAY      = `EMU_RAM_W_DELAY;
    localparam int MAX_INFLIGHT = `EMU_RAM_MAX_INFLIGHT;
    localparam int DEPTH        = `EMU_RAM_DEPTH;
    localparam int BYTES        = `EMU_RAM_DATA_W / 8;
    localparam logic [31:0] SEED = 32'h078d_1265;

    localparam int N_RAND      = 20;
    localparam int N_STRB      = 12;
    localparam int N_BP        = 10;
    localparam int N_BURSTS    = 2 * (N_RAND + N_STRB + N_BP) + 40;
    localparam int MAX_BEATS   = 64;
    localparam int BEAT_CYCLES = 4;    // worst case with random ready.
    localparam int MARGIN      = 4;
    localparam int WATCHDOG_NS = N_BURSTS * MAX_BEATS * BEAT_CYCLES * MARGIN * 10;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         awvalid;
    logic [`EMU_RAM_ID_W-1:0]     awid;
    logic [`EMU_RAM_ADDR_W-1:0]   awaddr;
    logic [7:0]                   awlen;
    logic [2:0]                   awsize;
    logic [1:0]                   awburst;
    logic                         awready;
    logic                         wvalid;
    logic [`EMU_RAM_DATA_W-1:0]   wdata;
    logic [BYTES-1:0]             wstrb;
    logic                         wlast;
    logic                         wready;
    logic [`EMU_RAM_ID_W-1:0]     bid;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready = 1'b0;
    logic                         arvalid;
    logic [`EMU_RAM_ID_W-1:0]     arid;
    logic [`EMU_RAM_ADDR_W-1:0]   araddr;
    logic [7:0]                   arlen;
    logic [2:0]                   arsize;
    logic [1:0]                   arburst;
    logic                         arready;
    logic [`EMU_RAM_ID_W-1:0]     rid;
    logic [`EMU_RAM_DATA_W-1:0]   rdata;
    logic [1:0]                   rresp;
    logic                         rlast;
    logic                         rvalid;
    logic                         rready = 1'b0;

    // reference model and expected responses.
    logic [`EMU_RAM_DATA_W-1:0]   model_mem [DEPTH];
    logic [`EMU_RAM_ID_W-1:0]     exp_rid [$];
    logic [`EMU_RAM_DATA_W-1:0]   exp_rdata [$];
    logic                         exp_rlast [$];
    logic [`EMU_RAM_ID_W-1:0]     exp_bid [$];

    logic [31:0] stim_lfsr = SEED;
    logic [31:0] rdy_lfsr  = SEED;
    logic        throttle  = 1'b0;    // random ready on B and R.
    int          cyc       = 0;
    int          check_errors = 0;
    int          other_errors = 0;
    int          ar_cyc;
    int          last_w_cyc;
    int          r_first_cyc;
    int          b_hs_cyc;
    int          r_beat_idx = 0;
    logic        r_stalled  = 1'b0;
    logic        b_stalled  = 1'b0;
    logic [`EMU_RAM_ID_W-1:0]   held_rid;
    logic [`EMU_RAM_ID_W-1:0]   held_bid;
    logic [`EMU_RAM_DATA_W-1:0] held_rdata;
    logic                       held_rlast;

    emu_ram i_emu_ram (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awid(awid), .awaddr(awaddr), .awlen(awlen),
        .awsize(awsize), .awburst(awburst), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wready(wready),
        .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .arvalid(arvalid), .arid(arid), .araddr(araddr), .arlen(arlen),
        .arsize(arsize), .arburst(arburst), .arready(arready),
        .rid(rid), .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid),
        .rready(rready)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic int word_index(input logic [15:0] addr, input int beat);
        return ((int'(addr) >> 2) + beat) % DEPTH;
    endfunction

    task automatic flag_mismatch(input string msg);
        check_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic check_quiet(input string where);
        if (awready !== 1'b0 || wready !== 1'b0 || arready !== 1'b0 ||
            bvalid !== 1'b0 || rvalid !== 1'b0) begin
            flag_mismatch($sformatf("control outputs not low %s", where));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // AXI master
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic write_burst(input logic [3:0] id, input logic [15:0] addr,
                               input logic [7:0] len, input logic full_strb);
        int          i;
        int          idx;
        logic [31:0] data;
        logic [3:0]  strb;
        awvalid = 1'b1;
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awsize  = 3'd2;
        awburst = 2'b01;
        #1;
        while (!awready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid = 1'b0;
        exp_bid.push_back(id);
        for (i = 0; i <= int'(len); i++) begin
            data   = rand_bits(32);
            strb   = full_strb ? 4'hf : rand_bits(4);
            wvalid = 1'b1;
            wdata  = data;
            wstrb  = strb;
            wlast  = (i == int'(len));
            #1;
            while (!wready) begin
                @(negedge clk);
                #1;
            end
            idx = word_index(addr, i);
            for (int b = 0; b < BYTES; b++) begin
                if (strb[b]) model_mem[idx][8*b +: 8] = data[8*b +: 8];
            end
            last_w_cyc = cyc;
            @(negedge clk);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [15:0] addr,
                              input logic [7:0] len);
        arvalid = 1'b1;
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arsize  = 3'd2;
        arburst = 2'b01;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        ar_cyc = cyc;
        for (int i = 0; i <= int'(len); i++) begin
            exp_rid.push_back(id);
            exp_rdata.push_back(model_mem[word_index(addr, i)]);
            exp_rlast.push_back(i == int'(len));
        end
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic wait_writes_done();
        while (exp_bid.size() != 0) @(negedge clk);
    endtask

    task automatic wait_reads_done();
        while (exp_rid.size() != 0) @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // response monitor
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic sample_r_channel();
        if (r_stalled && (rvalid !== 1'b1 || rid !== held_rid || rdata !== held_rdata ||
                          rlast !== held_rlast)) begin
            flag_mismatch("R beat changed before rready");
        end
        if (rvalid && rready) begin
            if (exp_rid.size() == 0) begin
                other_errors++;
                $display("unexpected R beat at %0t with no read outstanding", $time);
            end else begin
                if (rid !== exp_rid[0])
                    flag_mismatch($sformatf("rid %h, expected %h", rid, exp_rid[0]));
                if (rdata !== exp_rdata[0])
                    flag_mismatch($sformatf("rdata %h, expected %h", rdata, exp_rdata[0]));
                if (rlast !== exp_rlast[0])
                    flag_mismatch($sformatf("rlast %b, expected %b", rlast, exp_rlast[0]));
                if (rresp !== 2'b00)
                    flag_mismatch($sformatf("rresp %b, expected OKAY", rresp));
                void'(exp_rid.pop_front());
                void'(exp_rdata.pop_front());
                void'(exp_rlast.pop_front());
            end
            if (r_beat_idx == 0) r_first_cyc = cyc;
            r_beat_idx = rlast ? 0 : r_beat_idx + 1;
        end
        r_stalled  = rvalid && !rready;
        held_rid   = rid;
        held_rdata = rdata;
        held_rlast = rlast;
    endtask

    task automatic sample_b_channel();
        if (b_stalled && (bvalid !== 1'b1 || bid !== held_bid)) begin
            flag_mismatch("B response changed before bready");
        end
        if (bvalid && bready) begin
            if (exp_bid.size() == 0) begin
                other_errors++;
                $display("unexpected B response at %0t with no write outstanding", $time);
            end else begin
                if (bid !== exp_bid[0])
                    flag_mismatch($sformatf("bid %h, expected %h", bid, exp_bid[0]));
                if (bresp !== 2'b00)
                    flag_mismatch($sformatf("bresp %b, expected OKAY", bresp));
                void'(exp_bid.pop_front());
            end
            b_hs_cyc = cyc;
        end
        b_stalled = bvalid && !bready;
        held_bid  = bid;
    endtask

    always begin
        @(negedge clk);
        rdy_lfsr = lfsr_next(rdy_lfsr);
        rready   = !throttle || rdy_lfsr[0];
        rdy_lfsr = lfsr_next(rdy_lfsr);
        bready   = !throttle || rdy_lfsr[0];
        #1;
        if (!rst) begin
            sample_r_channel();
            sample_b_channel();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, responses still outstanding", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [15:0] addr;
        logic [7:0]  len;
        rst     = 1'b1;
        awvalid = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = 3'd2;
        awburst = 2'b01;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        arvalid = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = 3'd2;
        arburst = 2'b01;

        @(negedge clk);
        #1 check_quiet("in reset");
        @(negedge clk);
        rst = 1'b0;                     // two rising edges under reset.
        #1 check_quiet("at reset release");
        @(negedge clk);
        #1 check_quiet("in the first cycle after reset");
        @(negedge clk);

        // single beat with full strobes.
        write_burst(4'h5, 16'h0040, 8'd0, 1'b1);
        wait_writes_done();
        read_burst(4'ha, 16'h0040, 8'd0);
        wait_reads_done();

        // random INCR bursts with one across the top of the address space.
        write_burst(4'h3, 16'hfff8, 8'd7, 1'b1);
        wait_writes_done();
        read_burst(4'h3, 16'hfff8, 8'd7);
        wait_reads_done();
        for (int k = 0; k < N_RAND; k++) begin
            addr = rand_bits(16) & 16'hfffc;
            len  = rand_bits(4);
            write_burst(rand_bits(4), addr, len, 1'b1);
            wait_writes_done();
            read_burst(rand_bits(4), addr, len);
            wait_reads_done();
        end

        // partial strobes over freshly written words.
        for (int k = 0; k < N_STRB; k++) begin
            addr = rand_bits(16) & 16'hfffc;
            len  = rand_bits(4);
            write_burst(rand_bits(4), addr, len, 1'b1);
            write_burst(rand_bits(4), addr, len, 1'b0);
            wait_writes_done();
            read_burst(rand_bits(4), addr, len);
            wait_reads_done();
        end

        // back-pressure with more beats than the response credit.
        throttle = 1'b1;
        for (int k = 0; k < 12; k++) begin
            write_burst(rand_bits(4), rand_bits(16) & 16'hfffc, 8'd0, 1'b1);
        end
        wait_writes_done();
        for (int k = 0; k < N_BP; k++) begin
            addr = rand_bits(16) & 16'hfffc;
            len  = 8'(16 + (rand_bits(6) % (MAX_BEATS - 16)));
            write_burst(rand_bits(4), addr, len, rand_bits(1));
            wait_writes_done();
            read_burst(rand_bits(4), addr, len);   // left in flight on purpose.
        end
        wait_reads_done();
        throttle = 1'b0;
        repeat (4) @(negedge clk);

        // fixed latency with ready held high.
        write_burst(4'h7, 16'h0100, 8'd0, 1'b1);
        wait_writes_done();
        if (b_hs_cyc - last_w_cyc != W_DELAY + 1)
            flag_mismatch($sformatf("B latency %0d, expected %0d",
                                    b_hs_cyc - last_w_cyc, W_DELAY + 1));
        read_burst(4'h9, 16'h0100, 8'd3);
        wait_reads_done();
        if (r_first_cyc - ar_cyc != R_DELAY + 3)
            flag_mismatch($sformatf("R latency %0d, expected %0d",
                                    r_first_cyc - ar_cyc, R_DELAY + 3));

        repeat (R_DELAY + MAX_INFLIGHT + 4) @(negedge clk);   // catch stray beats.
        $display("closing: %0d check failures, %0d protocol failures",
                 check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
